//--- common/decode_pkg.sv
package decode_pkg;

    typedef logic [isa_pkg::num_regs-1:0] reg_mask_t; // one bit per register

    typedef struct packed {
        logic                          rc;   // source is a constant
        logic                          wb;   // byte operation
        logic                          prpo;
        logic                          dec;
        logic                          inc;
        logic [isa_pkg::reg_idx_w-1:0] src;
        logic [isa_pkg::reg_idx_w-1:0] dst;
        logic [isa_pkg::off_w-1:0]     off;
        logic [isa_pkg::byte_w-1:0]    lit;
    } operands_t;

    typedef struct packed {
        reg_mask_t set_mask; // registers written
        reg_mask_t dep_mask; // registers waited on
    } hazard_t;

    typedef struct packed {
        logic             valid;
        isa_pkg::opcode_e opcode;
        operands_t        operands;
    } decoded_t;

endpackage

//--- common/isa_pkg.sv
package isa_pkg;

    localparam int inst_w    = 16;
    localparam int reg_idx_w = 3;
    localparam int num_regs  = 8;
    localparam int off_w     = 13; // long branch offset
    localparam int byte_w    = 8;  // literal byte

    // operand field positions inside the instruction word
    localparam int rc_bit      = 7;
    localparam int wb_bit      = 6;
    localparam int prpo_bit    = 9;
    localparam int dec_bit     = 8;
    localparam int inc_bit     = 7;
    localparam int src_lsb     = 3;
    localparam int dst_lsb     = 0;
    localparam int lit_lsb     = 3;
    localparam int br_off_w    = 10; // conditional branch offset
    localparam int rel_off_lsb = 7;
    localparam int rel_off_w   = 7;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_BL, OP_BEQ, OP_BNE, OP_BC, OP_BNC, OP_BN, OP_BGE, OP_BLT, OP_BRA,
        OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_DADD, OP_CMP,
        OP_XOR, OP_AND, OP_OR, OP_BIT, OP_BIC, OP_BIS,
        OP_MOV, OP_SWAP,
        OP_SRA, OP_RRC, OP_COMP, OP_SWPB, OP_SXT,
        OP_LD, OP_ST,
        OP_MOVL, OP_MOVLZ, OP_MOVLS, OP_MOVH,
        OP_LDR, OP_STR
    } opcode_e;

    typedef enum logic [3:0] {
        FMT_NONE, FMT_BRANCH_LONG, FMT_BRANCH, FMT_ALU, FMT_MOV, FMT_SWAP,
        FMT_SINGLE_WB, FMT_SINGLE, FMT_MEM, FMT_LIT, FMT_REL
    } format_e;

    typedef struct packed {
        logic [inst_w-1:0] mask;
        logic [inst_w-1:0] match;
    } pattern_t;

    localparam pattern_t pat_bl    = '{16'hE000, 16'h0000};
    localparam pattern_t pat_beq   = '{16'hFC00, 16'h2000};
    localparam pattern_t pat_bne   = '{16'hFC00, 16'h2400};
    localparam pattern_t pat_bc    = '{16'hFC00, 16'h2800};
    localparam pattern_t pat_bnc   = '{16'hFC00, 16'h2C00};
    localparam pattern_t pat_bn    = '{16'hFC00, 16'h3000};
    localparam pattern_t pat_bge   = '{16'hFC00, 16'h3400};
    localparam pattern_t pat_blt   = '{16'hFC00, 16'h3800};
    localparam pattern_t pat_bra   = '{16'hFC00, 16'h3C00};
    localparam pattern_t pat_add   = '{16'hFF00, 16'h4000};
    localparam pattern_t pat_addc  = '{16'hFF00, 16'h4100};
    localparam pattern_t pat_sub   = '{16'hFF00, 16'h4200};
    localparam pattern_t pat_subc  = '{16'hFF00, 16'h4300};
    localparam pattern_t pat_dadd  = '{16'hFF00, 16'h4400};
    localparam pattern_t pat_cmp   = '{16'hFF00, 16'h4500};
    localparam pattern_t pat_xor   = '{16'hFF00, 16'h4600};
    localparam pattern_t pat_and   = '{16'hFF00, 16'h4700};
    localparam pattern_t pat_or    = '{16'hFF00, 16'h4800};
    localparam pattern_t pat_bit   = '{16'hFF00, 16'h4900};
    localparam pattern_t pat_bic   = '{16'hFF00, 16'h4A00};
    localparam pattern_t pat_bis   = '{16'hFF00, 16'h4B00};
    localparam pattern_t pat_mov   = '{16'hFF80, 16'h4C00};
    localparam pattern_t pat_swap  = '{16'hFF80, 16'h4C80};
    localparam pattern_t pat_sra   = '{16'hFFB8, 16'h4D00};
    localparam pattern_t pat_rrc   = '{16'hFFB8, 16'h4D08};
    localparam pattern_t pat_comp  = '{16'hFFB8, 16'h4D10};
    localparam pattern_t pat_swpb  = '{16'hFFB8, 16'h4D18};
    localparam pattern_t pat_sxt   = '{16'hFFB8, 16'h4D20};
    localparam pattern_t pat_ld    = '{16'hFC00, 16'h5800};
    localparam pattern_t pat_st    = '{16'hFC00, 16'h5C00};
    localparam pattern_t pat_movl  = '{16'hF800, 16'h6000};
    localparam pattern_t pat_movlz = '{16'hF800, 16'h6800};
    localparam pattern_t pat_movls = '{16'hF800, 16'h7000};
    localparam pattern_t pat_movh  = '{16'hF800, 16'h7800};
    localparam pattern_t pat_ldr   = '{16'hC000, 16'h8000};
    localparam pattern_t pat_str   = '{16'hC000, 16'hC000};

    localparam int num_pats = 36;

    // priority order, entry i decodes to opcode_e value i + 1
    localparam pattern_t pat_table [num_pats] = '{
        pat_bl, pat_beq, pat_bne, pat_bc, pat_bnc, pat_bn, pat_bge, pat_blt, pat_bra,
        pat_add, pat_addc, pat_sub, pat_subc, pat_dadd, pat_cmp,
        pat_xor, pat_and, pat_or, pat_bit, pat_bic, pat_bis,
        pat_mov, pat_swap,
        pat_sra, pat_rrc, pat_comp, pat_swpb, pat_sxt,
        pat_ld, pat_st,
        pat_movl, pat_movlz, pat_movls, pat_movh,
        pat_ldr, pat_str
    };

endpackage

//--- decode/hazard_mask_gen.sv
`timescale 1ns/1ns

module hazard_mask_gen (
    input  logic [isa_pkg::inst_w-1:0] inst,
    input  isa_pkg::opcode_e           opcode,
    output decode_pkg::hazard_t        hazard
);

    logic [isa_pkg::reg_idx_w-1:0] src;
    logic [isa_pkg::reg_idx_w-1:0] dst;
    decode_pkg::reg_mask_t         src_bit;
    decode_pkg::reg_mask_t         dst_bit;
    logic                          src_is_reg; // rc clear
    logic                          addr_upd;   // pre/post inc or dec

    assign src        = inst[isa_pkg::src_lsb +: isa_pkg::reg_idx_w];
    assign dst        = inst[isa_pkg::dst_lsb +: isa_pkg::reg_idx_w];
    assign src_bit    = decode_pkg::reg_mask_t'(1) << src;
    assign dst_bit    = decode_pkg::reg_mask_t'(1) << dst;
    assign src_is_reg = !inst[isa_pkg::rc_bit];
    assign addr_upd   = inst[isa_pkg::inc_bit] | inst[isa_pkg::dec_bit];

    always_comb begin
        hazard = '0; // branches and no instruction
        case (opcode)
            isa_pkg::OP_ADD, isa_pkg::OP_ADDC, isa_pkg::OP_SUB, isa_pkg::OP_SUBC,
            isa_pkg::OP_DADD, isa_pkg::OP_XOR, isa_pkg::OP_AND, isa_pkg::OP_OR,
            isa_pkg::OP_BIC, isa_pkg::OP_BIS: begin
                hazard.set_mask = dst_bit;
                hazard.dep_mask = dst_bit | (src_is_reg ? src_bit : '0);
            end
            isa_pkg::OP_CMP, isa_pkg::OP_BIT: begin // flags only, no write back
                hazard.dep_mask = dst_bit | (src_is_reg ? src_bit : '0);
            end
            isa_pkg::OP_MOV, isa_pkg::OP_LDR: begin
                hazard.set_mask = dst_bit;
                hazard.dep_mask = src_bit;
            end
            isa_pkg::OP_SWAP: begin
                hazard.set_mask = src_bit | dst_bit;
                hazard.dep_mask = src_bit | dst_bit;
            end
            isa_pkg::OP_SRA, isa_pkg::OP_RRC, isa_pkg::OP_COMP, isa_pkg::OP_SWPB,
            isa_pkg::OP_SXT, isa_pkg::OP_MOVL, isa_pkg::OP_MOVH: begin
                hazard.set_mask = dst_bit;
                hazard.dep_mask = dst_bit;
            end
            isa_pkg::OP_LD: begin
                hazard.set_mask = dst_bit | (addr_upd ? src_bit : '0); // pointer in src
                hazard.dep_mask = src_bit;
            end
            isa_pkg::OP_ST: begin
                hazard.set_mask = addr_upd ? dst_bit : '0; // pointer in dst
                hazard.dep_mask = src_bit | dst_bit;
            end
            isa_pkg::OP_MOVLZ, isa_pkg::OP_MOVLS: hazard.set_mask = dst_bit;
            isa_pkg::OP_STR: hazard.dep_mask = src_bit | dst_bit;
            default: ;
        endcase
    end

endmodule

//--- decode/opcode_classifier.sv
`timescale 1ns/1ns

module opcode_classifier (
    input  logic [isa_pkg::inst_w-1:0] inst,
    input  logic                       decode_disable,
    output isa_pkg::opcode_e           opcode,
    output isa_pkg::format_e           format
);

    always_comb begin
        opcode = isa_pkg::OP_NONE;
        if (!decode_disable) begin
            // walk up from the lowest priority so the earliest hit wins
            for (int i = isa_pkg::num_pats - 1; i >= 0; i--) begin
                if ((inst & isa_pkg::pat_table[i].mask) == isa_pkg::pat_table[i].match) begin
                    opcode = isa_pkg::opcode_e'(i + 1);
                end
            end
        end
    end

    always_comb begin
        case (opcode)
            isa_pkg::OP_BL: format = isa_pkg::FMT_BRANCH_LONG;
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BC, isa_pkg::OP_BNC,
            isa_pkg::OP_BN, isa_pkg::OP_BGE, isa_pkg::OP_BLT, isa_pkg::OP_BRA:
                format = isa_pkg::FMT_BRANCH;
            isa_pkg::OP_ADD, isa_pkg::OP_ADDC, isa_pkg::OP_SUB, isa_pkg::OP_SUBC,
            isa_pkg::OP_DADD, isa_pkg::OP_CMP, isa_pkg::OP_XOR, isa_pkg::OP_AND,
            isa_pkg::OP_OR, isa_pkg::OP_BIT, isa_pkg::OP_BIC, isa_pkg::OP_BIS:
                format = isa_pkg::FMT_ALU;
            isa_pkg::OP_MOV: format = isa_pkg::FMT_MOV;
            isa_pkg::OP_SWAP: format = isa_pkg::FMT_SWAP;
            isa_pkg::OP_SRA, isa_pkg::OP_RRC, isa_pkg::OP_COMP:
                format = isa_pkg::FMT_SINGLE_WB;
            isa_pkg::OP_SWPB, isa_pkg::OP_SXT: format = isa_pkg::FMT_SINGLE;
            isa_pkg::OP_LD, isa_pkg::OP_ST: format = isa_pkg::FMT_MEM;
            isa_pkg::OP_MOVL, isa_pkg::OP_MOVLZ, isa_pkg::OP_MOVLS, isa_pkg::OP_MOVH:
                format = isa_pkg::FMT_LIT;
            isa_pkg::OP_LDR, isa_pkg::OP_STR: format = isa_pkg::FMT_REL;
            default: format = isa_pkg::FMT_NONE; // nothing matched or disabled
        endcase
    end

endmodule

//--- decode/operand_unpack.sv
`timescale 1ns/1ns

module operand_unpack (
    input  logic [isa_pkg::inst_w-1:0] inst,
    input  isa_pkg::format_e           format,
    output decode_pkg::operands_t      operands
);

    logic has_wb;
    logic has_src;
    logic has_dst;
    logic is_mem;

    assign is_mem  = (format == isa_pkg::FMT_MEM);
    assign has_wb  = format inside {isa_pkg::FMT_ALU, isa_pkg::FMT_MOV,
                                    isa_pkg::FMT_SINGLE_WB, isa_pkg::FMT_MEM,
                                    isa_pkg::FMT_REL};
    assign has_src = format inside {isa_pkg::FMT_ALU, isa_pkg::FMT_MOV,
                                    isa_pkg::FMT_SWAP, isa_pkg::FMT_MEM,
                                    isa_pkg::FMT_REL};
    assign has_dst = has_src || format inside {isa_pkg::FMT_SINGLE_WB,
                                               isa_pkg::FMT_SINGLE, isa_pkg::FMT_LIT};

    always_comb begin
        operands      = '0;
        operands.rc   = inst[isa_pkg::rc_bit] & (format == isa_pkg::FMT_ALU);
        operands.wb   = inst[isa_pkg::wb_bit] & has_wb;
        operands.prpo = inst[isa_pkg::prpo_bit] & is_mem;
        operands.dec  = inst[isa_pkg::dec_bit] & is_mem;
        operands.inc  = inst[isa_pkg::inc_bit] & is_mem;
        if (has_src) begin
            operands.src = inst[isa_pkg::src_lsb +: isa_pkg::reg_idx_w];
        end
        if (has_dst) begin
            operands.dst = inst[isa_pkg::dst_lsb +: isa_pkg::reg_idx_w];
        end

        case (format)
            isa_pkg::FMT_BRANCH_LONG: operands.off = inst[isa_pkg::off_w-1:0];
            isa_pkg::FMT_BRANCH: begin
                operands.off = {{(isa_pkg::off_w - isa_pkg::br_off_w){1'b0}},
                                inst[isa_pkg::br_off_w-1:0]};
            end
            isa_pkg::FMT_REL: begin
                operands.off = {{(isa_pkg::off_w - isa_pkg::rel_off_w){1'b0}},
                                inst[isa_pkg::rel_off_lsb +: isa_pkg::rel_off_w]};
            end
            isa_pkg::FMT_LIT: operands.lit = inst[isa_pkg::lit_lsb +: isa_pkg::byte_w];
            default: ; // no offset or literal
        endcase
    end

endmodule

//--- decode_stage.f
common/isa_pkg.sv
common/decode_pkg.sv
decode/opcode_classifier.sv
decode/operand_unpack.sv
decode/hazard_mask_gen.sv
hdl/decode_register.sv
hdl/decode_stage.sv
tests/tb_clock.sv
tests/decode_stage_tb.sv

//--- hdl/decode_register.sv
`timescale 1ns/1ns

module decode_register (
    input  logic                  clk,
    input  logic                  arst_n,
    input  isa_pkg::opcode_e      opcode,
    input  decode_pkg::operands_t operands,
    input  decode_pkg::hazard_t   hazard_in,
    output decode_pkg::decoded_t  decoded,
    output decode_pkg::hazard_t   hazard
);

    decode_pkg::decoded_t decoded_d;

    always_comb begin
        decoded_d.valid    = (opcode != isa_pkg::OP_NONE);
        decoded_d.opcode   = opcode;
        decoded_d.operands = operands;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decoded <= '0; // opcode field clears to OP_NONE
            hazard  <= '0;
        end else begin
            decoded <= decoded_d;
            hazard  <= hazard_in;
        end
    end

    // no instruction must leave every field and mask quiet
    a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !decoded.valid |-> (decoded.operands == '0 && hazard == '0));

    // at most dst plus a pointer or swap partner
    a_set_two_max: assert property (@(posedge clk) disable iff (!arst_n)
        $countones(hazard.set_mask) <= 2);

    // valid only with a kept opcode, never OP_NONE or an unused code
    a_valid_opcode: assert property (@(posedge clk) disable iff (!arst_n)
        decoded.valid |-> decoded.opcode inside {[isa_pkg::OP_BL:isa_pkg::OP_STR]});

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [isa_pkg::inst_w-1:0] inst,
    input  logic                       decode_disable,
    output decode_pkg::decoded_t       decoded,
    output decode_pkg::hazard_t        hazard
);

    isa_pkg::opcode_e      opcode;
    isa_pkg::format_e      format;
    decode_pkg::operands_t operands;
    decode_pkg::hazard_t   hazard_c; // before the output flops

    opcode_classifier u_classifier (
        .inst           (inst),
        .decode_disable (decode_disable),
        .opcode         (opcode),
        .format         (format)
    );

    operand_unpack u_unpack (
        .inst     (inst),
        .format   (format),
        .operands (operands)
    );

    hazard_mask_gen u_hazard (
        .inst   (inst),
        .opcode (opcode),
        .hazard (hazard_c)
    );

    decode_register u_register (
        .clk       (clk),
        .arst_n    (arst_n),
        .opcode    (opcode),
        .operands  (operands),
        .hazard_in (hazard_c),
        .decoded   (decoded),
        .hazard    (hazard)
    );

endmodule

//--- tests/decode_stage_tb.sv
`timescale 1ns/1ns

module decode_stage_tb;

    localparam int num_pats       = 36;
    localparam int random_words   = 400;
    localparam int timeout_cycles = 600; // about 470 cycles of stimulus plus margin

    // kept encodings, highest priority first
    localparam logic [15:0] tbl_mask [num_pats] = '{
        16'hE000, 16'hFC00, 16'hFC00, 16'hFC00, 16'hFC00, 16'hFC00, 16'hFC00, 16'hFC00, 16'hFC00,
        16'hFF00, 16'hFF00, 16'hFF00, 16'hFF00, 16'hFF00, 16'hFF00,
        16'hFF00, 16'hFF00, 16'hFF00, 16'hFF00, 16'hFF00, 16'hFF00,
        16'hFF80, 16'hFF80, 16'hFFB8, 16'hFFB8, 16'hFFB8, 16'hFFB8, 16'hFFB8,
        16'hFC00, 16'hFC00, 16'hF800, 16'hF800, 16'hF800, 16'hF800, 16'hC000, 16'hC000
    };
    localparam logic [15:0] tbl_match [num_pats] = '{
        16'h0000, 16'h2000, 16'h2400, 16'h2800, 16'h2C00, 16'h3000, 16'h3400, 16'h3800, 16'h3C00,
        16'h4000, 16'h4100, 16'h4200, 16'h4300, 16'h4400, 16'h4500,
        16'h4600, 16'h4700, 16'h4800, 16'h4900, 16'h4A00, 16'h4B00,
        16'h4C00, 16'h4C80, 16'h4D00, 16'h4D08, 16'h4D10, 16'h4D18, 16'h4D20,
        16'h5800, 16'h5C00, 16'h6000, 16'h6800, 16'h7000, 16'h7800, 16'h8000, 16'hC000
    };
    localparam isa_pkg::opcode_e tbl_op [num_pats] = '{
        isa_pkg::OP_BL, isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BC, isa_pkg::OP_BNC,
        isa_pkg::OP_BN, isa_pkg::OP_BGE, isa_pkg::OP_BLT, isa_pkg::OP_BRA,
        isa_pkg::OP_ADD, isa_pkg::OP_ADDC, isa_pkg::OP_SUB, isa_pkg::OP_SUBC, isa_pkg::OP_DADD,
        isa_pkg::OP_CMP, isa_pkg::OP_XOR, isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_BIT,
        isa_pkg::OP_BIC, isa_pkg::OP_BIS, isa_pkg::OP_MOV, isa_pkg::OP_SWAP,
        isa_pkg::OP_SRA, isa_pkg::OP_RRC, isa_pkg::OP_COMP, isa_pkg::OP_SWPB, isa_pkg::OP_SXT,
        isa_pkg::OP_LD, isa_pkg::OP_ST, isa_pkg::OP_MOVL, isa_pkg::OP_MOVLZ, isa_pkg::OP_MOVLS,
        isa_pkg::OP_MOVH, isa_pkg::OP_LDR, isa_pkg::OP_STR
    };

    // rc, inc/dec and same-register cases
    localparam logic [15:0] corner_words [10] = '{
        16'h4011, 16'h4091, 16'h4513, 16'h4995, 16'h580A,
        16'h588A, 16'h5B0A, 16'h5C0A, 16'h5D8A, 16'h4C89
    };
    // SETPRI, SVC, SETCC, CLRCC, CEX and two gaps
    localparam logic [15:0] no_op_words [7] = '{
        16'h4D82, 16'h4D93, 16'h4DB5, 16'h4DD1, 16'h5123, 16'h4D28, 16'h5400
    };

    logic                    clk;
    logic                    arst_n;
    logic [15:0]             inst;
    logic                    decode_disable;
    decode_pkg::decoded_t    decoded;
    decode_pkg::hazard_t     hazard;
    decode_pkg::decoded_t    exp_dec;
    decode_pkg::hazard_t     exp_hz;
    logic                    dis_q;
    logic                    settle;      // reset or first edge after it
    int                      cur_idx;
    int                      cycle_count = 0;
    string                   stim_name   = "reset";
    string                   name_q1     = "reset";
    string                   name_q2     = "reset"; // instruction under check

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    decode_stage DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .inst           (inst),
        .decode_disable (decode_disable),
        .decoded        (decoded),
        .hazard         (hazard)
    );

    // first matching pattern, -1 for none or disabled
    function automatic int classify(logic [15:0] w, logic dis);
        if (dis) return -1;
        for (int i = 0; i < num_pats; i++) begin
            if ((w & tbl_mask[i]) == tbl_match[i]) return i;
        end
        return -1;
    endfunction

    function automatic isa_pkg::opcode_e opcode_at(int idx);
        return (idx < 0) ? isa_pkg::OP_NONE : tbl_op[idx];
    endfunction

    function automatic isa_pkg::format_e format_of(int idx);
        if (idx == 0) return isa_pkg::FMT_BRANCH_LONG;
        else if (idx <= 8) return isa_pkg::FMT_BRANCH;
        else if (idx <= 20) return isa_pkg::FMT_ALU;
        else if (idx == 21) return isa_pkg::FMT_MOV;
        else if (idx == 22) return isa_pkg::FMT_SWAP;
        else if (idx <= 25) return isa_pkg::FMT_SINGLE_WB;
        else if (idx <= 27) return isa_pkg::FMT_SINGLE;
        else if (idx <= 29) return isa_pkg::FMT_MEM;
        else if (idx <= 33) return isa_pkg::FMT_LIT;
        return isa_pkg::FMT_REL;
    endfunction

    function automatic decode_pkg::decoded_t expected_word(logic [15:0] w, int idx);
        decode_pkg::decoded_t d;
        d = '0;
        if (idx < 0) return d;
        d.valid  = 1'b1;
        d.opcode = tbl_op[idx];
        case (format_of(idx))
            isa_pkg::FMT_BRANCH_LONG: d.operands.off = w[12:0];
            isa_pkg::FMT_BRANCH: d.operands.off = {3'b000, w[9:0]};
            isa_pkg::FMT_ALU: begin
                d.operands.rc = w[7];
                d.operands.wb = w[6];
                d.operands.src = w[5:3];
                d.operands.dst = w[2:0];
            end
            isa_pkg::FMT_MOV: begin
                d.operands.wb = w[6];
                d.operands.src = w[5:3];
                d.operands.dst = w[2:0];
            end
            isa_pkg::FMT_SWAP: begin
                d.operands.src = w[5:3];
                d.operands.dst = w[2:0];
            end
            isa_pkg::FMT_SINGLE_WB: begin
                d.operands.wb = w[6];
                d.operands.dst = w[2:0];
            end
            isa_pkg::FMT_SINGLE: d.operands.dst = w[2:0];
            isa_pkg::FMT_MEM: begin
                d.operands.prpo = w[9];
                d.operands.dec = w[8];
                d.operands.inc = w[7];
                d.operands.wb = w[6];
                d.operands.src = w[5:3];
                d.operands.dst = w[2:0];
            end
            isa_pkg::FMT_LIT: begin
                d.operands.lit = w[10:3];
                d.operands.dst = w[2:0];
            end
            default: begin // relative load and store
                d.operands.off = {6'b000000, w[13:7]};
                d.operands.wb = w[6];
                d.operands.src = w[5:3];
                d.operands.dst = w[2:0];
            end
        endcase
        return d;
    endfunction

    function automatic decode_pkg::hazard_t hazard_masks(logic [15:0] w, isa_pkg::opcode_e op);
        decode_pkg::hazard_t h;
        logic [7:0]          s;
        logic [7:0]          d;
        logic                upd;
        h   = '0;
        s   = 8'b1 << w[5:3];
        d   = 8'b1 << w[2:0];
        upd = w[7] | w[8]; // inc or dec
        case (op)
            isa_pkg::OP_CMP, isa_pkg::OP_BIT: h.dep_mask = d | (w[7] ? 8'h00 : s);
            isa_pkg::OP_ADD, isa_pkg::OP_ADDC, isa_pkg::OP_SUB, isa_pkg::OP_SUBC,
            isa_pkg::OP_DADD, isa_pkg::OP_XOR, isa_pkg::OP_AND, isa_pkg::OP_OR,
            isa_pkg::OP_BIC, isa_pkg::OP_BIS: begin
                h.set_mask = d;
                h.dep_mask = d | (w[7] ? 8'h00 : s);
            end
            isa_pkg::OP_MOV, isa_pkg::OP_LDR: begin
                h.set_mask = d;
                h.dep_mask = s;
            end
            isa_pkg::OP_SWAP: h = {s | d, s | d};
            isa_pkg::OP_SRA, isa_pkg::OP_RRC, isa_pkg::OP_COMP, isa_pkg::OP_SWPB,
            isa_pkg::OP_SXT, isa_pkg::OP_MOVL, isa_pkg::OP_MOVH: h = {d, d};
            isa_pkg::OP_LD: h = {d | (upd ? s : 8'h00), s};
            isa_pkg::OP_ST: h = {(upd ? d : 8'h00), s | d};
            isa_pkg::OP_MOVLZ, isa_pkg::OP_MOVLS: h.set_mask = d;
            isa_pkg::OP_STR: h.dep_mask = s | d;
            default: ; // branches and no instruction
        endcase
        return h;
    endfunction

    task automatic report_mismatch(string check, logic [63:0] expv, logic [63:0] actv);
        $display("FAILED %s on %s: expected 0x%0h, actual 0x%0h", check, name_q2, expv, actv);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic drive(string name, logic [15:0] w, logic dis);
        @(negedge clk);
        stim_name      = name;
        inst           = w;
        decode_disable = dis;
    endtask

    always_comb begin
        cur_idx = classify(inst, decode_disable);
    end

    // one-entry model of the output register
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_dec <= '0;
            exp_hz  <= '0;
            dis_q   <= 1'b0;
            settle  <= 1'b1;
        end else begin
            exp_dec <= expected_word(inst, cur_idx);
            exp_hz  <= hazard_masks(inst, opcode_at(cur_idx));
            dis_q   <= decode_disable;
            settle  <= 1'b0;
        end
    end

    always @(posedge clk) begin
        name_q1 <= stim_name;
        name_q2 <= name_q1;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    a_valid: assert property (@(posedge clk) decoded.valid == exp_dec.valid)
        else report_mismatch("valid", $sampled(exp_dec.valid), $sampled(decoded.valid));
    a_opcode: assert property (@(posedge clk) decoded.opcode == exp_dec.opcode)
        else report_mismatch("opcode", $sampled(exp_dec.opcode), $sampled(decoded.opcode));
    a_operands: assert property (@(posedge clk) decoded.operands == exp_dec.operands)
        else report_mismatch("operands", $sampled(exp_dec.operands),
                             $sampled(decoded.operands));
    a_set_mask: assert property (@(posedge clk) hazard.set_mask == exp_hz.set_mask)
        else report_mismatch("set_mask", $sampled(exp_hz.set_mask), $sampled(hazard.set_mask));
    a_dep_mask: assert property (@(posedge clk) hazard.dep_mask == exp_hz.dep_mask)
        else report_mismatch("dep_mask", $sampled(exp_hz.dep_mask), $sampled(hazard.dep_mask));
    a_reset_quiet: assert property (@(posedge clk) settle |-> (!decoded.valid && hazard == '0))
        else report_mismatch("reset quiet", '0, {$sampled(decoded.valid), $sampled(hazard)});
    a_disable_quiet: assert property (@(posedge clk) dis_q |-> (decoded == '0 && hazard == '0))
        else report_mismatch("disable quiet", '0, {$sampled(decoded), $sampled(hazard)});

    initial begin
        logic [15:0] w;
        void'($urandom(32'h18ef_ca41));
        inst           = '0;
        decode_disable = 1'b1; // also covers the first edge after reset
        @(posedge arst_n);
        for (int i = 0; i < num_pats; i++) begin
            w = tbl_match[i] | (16'($urandom()) & ~tbl_mask[i]); // free bits random
            drive(tbl_op[i].name(), w, 1'b0);
        end
        foreach (corner_words[i]) begin
            drive($sformatf("corner %h", corner_words[i]), corner_words[i], 1'b0);
        end
        foreach (no_op_words[i]) begin
            drive($sformatf("no-op %h", no_op_words[i]), no_op_words[i], 1'b0);
        end
        drive("disabled ADD", 16'h4011, 1'b1);
        drive("ADD after disable", 16'h4011, 1'b0);
        drive("disabled LD", 16'h588A, 1'b1);
        drive("disabled BL", 16'h0123, 1'b1);
        for (int i = 0; i < random_words; i++) begin
            w = 16'($urandom());
            drive($sformatf("random %0d (%h)", i, w), w, ($urandom() % 8) == 0);
        end
        drive("idle", 16'h0000, 1'b1);
        repeat (2) @(posedge clk); // last result reaches the checks
        @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam int half_period  = 50; // 100 ns clock
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        arst_n = 1'b1;
        #1 arst_n = 1'b0; // clean falling edge for the async flops
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1; // release away from the active edge
    end

endmodule
